// ==== project.f ====
+incdir+include
verilog/fm_mix_pkg.sv
verilog/fm_slot_counter.sv
verilog/fm_chan_regs.sv
verilog/fm_single_acc.sv
verilog/fm_acc.sv
verilog/fm_mix_top.sv
verif/fm_mix_tb.sv

// ==== Makefile ====
# Verilator flow for the FM output mixer
TOP := fm_mix_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal +incdir+include --top-module fm_mix_top \
		verilog/fm_mix_pkg.sv verilog/fm_slot_counter.sv verilog/fm_chan_regs.sv \
		verilog/fm_single_acc.sv verilog/fm_acc.sv verilog/fm_mix_top.sv
	verilator --lint-only -Wall -Wno-fatal --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qF "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/fm_mix_tb.sv ====
// ==========================================================================
// Testbench for fm_mix_top. Assumes FM_MIX_NOMIX is 0 and a 32-slot frame;
// the model tracks its own slot, registers and sums and checks each frame
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "fm_mix_params.svh"

module fm_mix_tb;

    import fm_mix_pkg::*;

    typedef logic signed [`FM_OP_W-1:0]  op_data_t;
    typedef logic signed [`FM_SND_W-1:0] snd_t;

    // op_result stimulus kinds
    localparam int op_zero      = 0;
    localparam int op_small     = 1;
    localparam int op_fixed     = 2;
    localparam int op_dead_only = 3;

    // 38 frames, 4 cycles per slot at worst, x2 margin
    localparam int total_frames   = 38;
    localparam int timeout_cycles = total_frames * `FM_SLOTS * 4 * 2;

    logic     clk;
    logic     reset;
    logic     clk_en;
    op_data_t op_result;
    logic     reg_we;
    ch_t      reg_ch;
    alg_t     reg_alg;
    rl_t      reg_rl;
    snd_t     adpcm_a_l;
    snd_t     adpcm_a_r;
    snd_t     adpcm_b_l;
    snd_t     adpcm_b_r;
    ch_t      cur_ch;
    op_t      cur_op;
    logic     zero;
    snd_t     left;
    snd_t     right;

    // Reference model state
    alg_t  m_alg [8];
    rl_t   m_rl [8];
    slot_t m_slot;
    int    m_sum_l;
    int    m_sum_r;
    snd_t  exp_left;
    snd_t  exp_right;
    int    frames_done;

    int    op_mode;
    int    op_value;
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;
    int    cycle_count = 0;
    string test_name;

    fm_mix_top fm_mix_top_i (
        .clk(clk), .reset(reset), .clk_en(clk_en), .op_result(op_result),
        .reg_we(reg_we), .reg_ch(reg_ch), .reg_alg(reg_alg), .reg_rl(reg_rl),
        .adpcm_a_l(adpcm_a_l), .adpcm_a_r(adpcm_a_r),
        .adpcm_b_l(adpcm_b_l), .adpcm_b_r(adpcm_b_r),
        .cur_ch(cur_ch), .cur_op(cur_op), .zero(zero), .left(left), .right(right)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // A frame lands on the zero edge, so check one edge later
    left_frame_check: assert property (
        @(posedge clk) disable iff (reset) (clk_en && zero) |=> (left == exp_left)
    ) else begin
        errors++;
        $display("error: %s left expected %0d actual %0d", test_name, exp_left, left);
    end

    right_frame_check: assert property (
        @(posedge clk) disable iff (reset) (clk_en && zero) |=> (right == exp_right)
    ) else begin
        errors++;
        $display("error: %s right expected %0d actual %0d", test_name, exp_right, right);
    end

    // Outputs hold between frame edges
    output_hold_check: assert property (
        @(posedge clk) disable iff (reset)
            !(clk_en && zero) |=> ($stable(left) && $stable(right))
    ) else begin
        errors++;
        $display("%s: left or right changed away from a frame edge", test_name);
    end

    // Carrier operators per algorithm
    function automatic logic carrier(alg_t a, op_t op);
        case (a)
            3'd4:       return (op == 2'd1) || (op == 2'd3);
            3'd5, 3'd6: return op != 2'd0;
            3'd7:       return 1'b1;
            default:    return op == 2'd3;
        endcase
    endfunction

    function automatic snd_t clamp16(int v);
        if (v > 32767) return 16'sh7fff;
        if (v < -32768) return 16'sh8000;
        return v[15:0];
    endfunction

    // Low 16 bits as a signed value
    function automatic int wrap16(int v);
        snd_t t;
        t = v[15:0];
        return int'(t);
    endfunction

    // One slot of the model; runs at the falling edge after the inputs
    task automatic step_model();
        op_t op;
        ch_t ch;
        int  term_l;
        int  term_r;
        op = m_slot[4:3];
        ch = m_slot[2:0];
        term_l = 0;
        term_r = 0;
        if (op == 2'd0 && ch == 3'd2) begin
            term_l = (`FM_MIX_NOMIX == 0) ? wrap16(int'(adpcm_a_l) * 16) : 0;
            term_r = (`FM_MIX_NOMIX == 0) ? wrap16(int'(adpcm_a_r) * 16) : 0;
        end else if (op == 2'd0 && ch == 3'd6) begin
            term_l = (`FM_MIX_NOMIX == 0) ? (int'(adpcm_b_l) >>> 1) : 0;
            term_r = (`FM_MIX_NOMIX == 0) ? (int'(adpcm_b_r) >>> 1) : 0;
        end else if (ch != 3'd3 && ch != 3'd7 && carrier(m_alg[ch], op)) begin
            // Pan bit 1 left, bit 0 right
            if (m_rl[ch][1]) term_l = int'(op_result);
            if (m_rl[ch][0]) term_r = int'(op_result);
        end
        if (clk_en) begin
            if (m_slot == 5'd0) begin
                exp_left  = clamp16(m_sum_l);
                exp_right = clamp16(m_sum_r);
                m_sum_l   = term_l;
                m_sum_r   = term_r;
                frames_done++;
            end else begin
                m_sum_l += term_l;
                m_sum_r += term_r;
            end
            m_slot = m_slot + 5'd1;
        end
    endtask

    task automatic run_frames(input int n);
        int target;
        target = frames_done + n;
        while (frames_done < target) begin
            @(negedge clk);
            slot_order_check: assert ({cur_op, cur_ch} == m_slot) else begin
                errors++;
                $display("error: %s slot expected %0d actual %0d",
                         test_name, m_slot, {cur_op, cur_ch});
            end
            zero_pulse_check: assert (zero == (m_slot == 5'd0)) else begin
                errors++;
                $display("error: %s zero expected %b actual %b",
                         test_name, m_slot == 5'd0, zero);
            end
            clk_en = ($urandom % 4) != 0;
            case (op_mode)
                op_small:     op_result = op_data_t'(int'($urandom_range(2047)) - 1024);
                op_fixed:     op_result = op_data_t'(op_value);
                op_dead_only: op_result = (cur_ch[1:0] == 2'b11) ? op_data_t'(op_value) : '0;
                default:      op_result = '0;
            endcase
            step_model();
        end
    endtask

    // Hold the slot for a cycle so inputs can change safely
    task automatic idle_cycle();
        @(negedge clk);
        clk_en = 1'b0;
    endtask

    task automatic write_channel(input ch_t ch, input alg_t a, input rl_t r);
        idle_cycle();
        reg_we  = 1'b1;
        reg_ch  = ch;
        reg_alg = a;
        reg_rl  = r;
        m_alg[ch] = a;
        m_rl[ch]  = r;
        @(negedge clk);
        reg_we = 1'b0;
    endtask

    task automatic set_all_channels(input alg_t a, input rl_t r);
        for (int ch = 0; ch < 8; ch++) begin
            write_channel(ch_t'(ch), a, r);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    // Lets the last frame reach its check before the verdict
    task automatic end_test();
        idle_cycle();
        idle_cycle();
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    initial begin
        void'($urandom(70));
        reset = 1'b1;
        clk_en = 1'b0;
        op_result = '0;
        reg_we = 1'b0;
        reg_ch = '0;
        reg_alg = '0;
        reg_rl = '0;
        adpcm_a_l = '0;
        adpcm_a_r = '0;
        adpcm_b_l = '0;
        adpcm_b_r = '0;
        for (int i = 0; i < 8; i++) begin
            m_alg[i] = 3'd0;
            m_rl[i]  = 2'b11;
        end
        m_slot = '0;
        m_sum_l = 0;
        m_sum_r = 0;
        exp_left = '0;
        exp_right = '0;
        frames_done = 0;
        op_mode = op_zero;
        op_value = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_name = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        begin_test("reset_idle");
        run_frames(2);
        end_test();

        // Every algorithm on every channel, small values avoid clamping
        begin_test("algorithms");
        op_mode = op_small;
        for (int a = 0; a < 8; a++) begin
            set_all_channels(alg_t'(a), 2'b11);
            run_frames(2);
        end
        end_test();

        begin_test("pan");
        set_all_channels(3'd7, 2'b10);
        run_frames(2);
        set_all_channels(3'd7, 2'b01);
        run_frames(2);
        set_all_channels(3'd7, 2'b00);
        run_frames(2);
        end_test();

        // FM silent, ADPCM-A kept within +-2047
        begin_test("adpcm");
        op_mode = op_zero;
        for (int i = 0; i < 3; i++) begin
            idle_cycle();
            adpcm_a_l = snd_t'(int'($urandom_range(4094)) - 2047);
            adpcm_a_r = snd_t'(int'($urandom_range(4094)) - 2047);
            adpcm_b_l = snd_t'($urandom);
            adpcm_b_r = snd_t'($urandom);
            run_frames(2);
        end
        idle_cycle();
        adpcm_a_l = '0;
        adpcm_a_r = '0;
        adpcm_b_l = '0;
        adpcm_b_r = '0;
        end_test();

        begin_test("saturation");
        set_all_channels(3'd7, 2'b11);
        op_mode = op_fixed;
        op_value = 8191;
        run_frames(2);
        op_value = -8192;
        run_frames(2);
        end_test();

        // Full scale only in slots of codes 3 and 7
        begin_test("dead_channels");
        op_mode = op_dead_only;
        op_value = 8191;
        run_frames(2);
        op_mode = op_small;
        run_frames(2);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/fm_mix_top.sv ====
// ==========================================================================
// FM output mixer. op_result must match the cur_ch/cur_op shown in the same
// cycle; left/right update at the zero edge with the previous frame
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "fm_mix_params.svh"

module fm_mix_top (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          clk_en,
    input  wire signed [`FM_OP_W-1:0]    op_result,
    input  wire                          reg_we,
    input  fm_mix_pkg::ch_t              reg_ch,
    input  fm_mix_pkg::alg_t             reg_alg,
    input  fm_mix_pkg::rl_t              reg_rl,
    input  wire signed [`FM_SND_W-1:0]   adpcm_a_l,
    input  wire signed [`FM_SND_W-1:0]   adpcm_a_r,
    input  wire signed [`FM_SND_W-1:0]   adpcm_b_l,
    input  wire signed [`FM_SND_W-1:0]   adpcm_b_r,
    output fm_mix_pkg::ch_t              cur_ch,
    output fm_mix_pkg::op_t              cur_op,
    output logic                         zero,
    output logic signed [`FM_SND_W-1:0]  left,
    output logic signed [`FM_SND_W-1:0]  right
);

    import fm_mix_pkg::*;

    // Operator strobes
    logic s1_enters;
    logic s2_enters;
    logic s3_enters;
    logic s4_enters;

    // Current channel setup
    alg_t alg;
    rl_t  rl;

    // Slot timing
    fm_slot_counter u_slot_counter (
        .clk       (clk),
        .reset     (reset),
        .clk_en    (clk_en),
        .cur_ch    (cur_ch),
        .cur_op    (cur_op),
        .s1_enters (s1_enters),
        .s2_enters (s2_enters),
        .s3_enters (s3_enters),
        .s4_enters (s4_enters),
        .zero      (zero)
    );

    // Channel setup bank
    fm_chan_regs u_chan_regs (
        .clk     (clk),
        .reset   (reset),
        .reg_we  (reg_we),
        .reg_ch  (reg_ch),
        .reg_alg (reg_alg),
        .reg_rl  (reg_rl),
        .cur_ch  (cur_ch),
        .alg     (alg),
        .rl      (rl)
    );

    // Mixer
    fm_acc u_acc (
        .clk       (clk),
        .reset     (reset),
        .clk_en    (clk_en),
        .op_result (op_result),
        .rl        (rl),
        .zero      (zero),
        .s1_enters (s1_enters),
        .s2_enters (s2_enters),
        .s3_enters (s3_enters),
        .s4_enters (s4_enters),
        .cur_ch    (cur_ch),
        .cur_op    (cur_op),
        .alg       (alg),
        .adpcm_a_l (adpcm_a_l),
        .adpcm_a_r (adpcm_a_r),
        .adpcm_b_l (adpcm_b_l),
        .adpcm_b_r (adpcm_b_r),
        .left      (left),
        .right     (right)
    );

endmodule

`default_nettype wire

// ==== verilog/fm_acc.sv ====
// ==========================================================================
// Slot-wise input choice for the two accumulators. ADPCM-A owns slot op 0 /
// ch 2, ADPCM-B owns op 0 / ch 6; codes 3 and 7 never add anything
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "fm_mix_params.svh"

module fm_acc (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          clk_en,
    input  wire signed [`FM_OP_W-1:0]    op_result,
    input  fm_mix_pkg::rl_t              rl,
    input  wire                          zero,
    input  wire                          s1_enters,
    input  wire                          s2_enters,
    input  wire                          s3_enters,
    input  wire                          s4_enters,
    input  fm_mix_pkg::ch_t              cur_ch,
    input  fm_mix_pkg::op_t              cur_op,
    input  fm_mix_pkg::alg_t             alg,
    input  wire signed [`FM_SND_W-1:0]   adpcm_a_l,
    input  wire signed [`FM_SND_W-1:0]   adpcm_a_r,
    input  wire signed [`FM_SND_W-1:0]   adpcm_b_l,
    input  wire signed [`FM_SND_W-1:0]   adpcm_b_r,
    output logic signed [`FM_SND_W-1:0]  left,
    output logic signed [`FM_SND_W-1:0]  right
);

    import fm_mix_pkg::*;

    // Slots borrowed from FM by the ADPCM units
    localparam op_t adpcm_op   = 2'd0;
    localparam ch_t adpcm_a_ch = 3'd2;
    localparam ch_t adpcm_b_ch = 3'd6;

    // ADPCM enable, off when the no-mix switch is set
    localparam logic adpcm_mix = ~`FM_MIX_NOMIX;

    logic                        sum_en;
    logic                        dead_ch;
    logic signed [`FM_SND_W-1:0] opext;
    logic signed [`FM_SND_W-1:0] acc_input_l;
    logic signed [`FM_SND_W-1:0] acc_input_r;
    logic                        acc_en_l;
    logic                        acc_en_r;

    // Carrier operators per algorithm
    always_comb begin
        case (alg)
            3'd4:       sum_en = s2_enters | s4_enters;
            3'd5, 3'd6: sum_en = s2_enters | s3_enters | s4_enters;
            3'd7:       sum_en = s1_enters | s2_enters | s3_enters | s4_enters;
            default:    sum_en = s4_enters;
        endcase
    end

    // Codes 3 and 7 are empty slots
    assign dead_ch = (cur_ch[1:0] == 2'b11);

    // Operator output widened to sample width
    assign opext = {{(`FM_SND_W - `FM_OP_W){op_result[`FM_OP_W-1]}}, op_result};

    always_comb begin
        acc_input_l = opext;
        acc_input_r = opext;
        acc_en_l    = sum_en & rl[1] & ~dead_ch;
        acc_en_r    = sum_en & rl[0] & ~dead_ch;
        if (cur_op == adpcm_op && cur_ch == adpcm_a_ch) begin
            // ADPCM-A, x16 and low 16 bits kept
            acc_input_l = adpcm_a_l <<< 4;
            acc_input_r = adpcm_a_r <<< 4;
            acc_en_l    = adpcm_mix;
            acc_en_r    = adpcm_mix;
        end else if (cur_op == adpcm_op && cur_ch == adpcm_b_ch) begin
            // ADPCM-B, halved with sign kept
            acc_input_l = adpcm_b_l >>> 1;
            acc_input_r = adpcm_b_r >>> 1;
            acc_en_l    = adpcm_mix;
            acc_en_r    = adpcm_mix;
        end
    end

    // Left side
    fm_single_acc #(.win(`FM_SND_W), .wout(`FM_SND_W)) u_left (
        .clk       (clk),
        .reset     (reset),
        .clk_en    (clk_en),
        .op_result (acc_input_l),
        .sum_en    (acc_en_l),
        .zero      (zero),
        .snd       (left)
    );

    // Right side
    fm_single_acc #(.win(`FM_SND_W), .wout(`FM_SND_W)) u_right (
        .clk       (clk),
        .reset     (reset),
        .clk_en    (clk_en),
        .op_result (acc_input_r),
        .sum_en    (acc_en_r),
        .zero      (zero),
        .snd       (right)
    );

endmodule

`default_nettype wire

// ==== verilog/fm_single_acc.sv ====
// ==========================================================================
// One-side frame accumulator. Needs win + FM_ACC_GUARD > wout; the running
// sum is clamped to wout bits only when it is latched at zero
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "fm_mix_params.svh"

module fm_single_acc #(
    parameter int win  = `FM_SND_W,
    parameter int wout = `FM_SND_W
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     clk_en,
    input  wire signed [win-1:0]    op_result,
    input  wire                     sum_en,
    input  wire                     zero,
    output logic signed [wout-1:0]  snd
);

    // Running sum width with headroom
    localparam int sum_w = win + `FM_ACC_GUARD;

    // Clamp limits in the output range
    localparam logic signed [wout-1:0] snd_max = {1'b0, {(wout - 1){1'b1}}};
    localparam logic signed [wout-1:0] snd_min = {1'b1, {(wout - 1){1'b0}}};

    logic signed [sum_w-1:0] sum;
    logic signed [sum_w-1:0] term;
    logic signed [wout-1:0]  sat;
    logic                    overflow;

    // Gated and sign-extended input
    assign term = sum_en ? {{`FM_ACC_GUARD{op_result[win-1]}}, op_result} : '0;

    // Out of range if the bits above the output sign disagree
    assign overflow = ~(&sum[sum_w-1:wout-1]) & (|sum[sum_w-1:wout-1]);

    // Clamp toward the sign of the full sum
    always_comb begin
        if (overflow) begin
            sat = sum[sum_w-1] ? snd_min : snd_max;
        end else begin
            sat = sum[wout-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sum <= '0;
            snd <= '0;
        end else if (clk_en) begin
            if (zero) begin
                // Close the old frame, open the new one with slot 0
                snd <= sat;
                sum <= term;
            end else begin
                sum <= sum + term;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fm_chan_regs.sv ====
// ==========================================================================
// Per-channel algorithm and pan bank. Writes ignore clk_en and show on the
// read port one cycle later. Reset gives alg 0 with both sides on
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module fm_chan_regs (
    input  wire               clk,
    input  wire               reset,
    input  wire               reg_we,
    input  fm_mix_pkg::ch_t   reg_ch,
    input  fm_mix_pkg::alg_t  reg_alg,
    input  fm_mix_pkg::rl_t   reg_rl,
    input  fm_mix_pkg::ch_t   cur_ch,
    output fm_mix_pkg::alg_t  alg,
    output fm_mix_pkg::rl_t   rl
);

    import fm_mix_pkg::*;

    // One entry per channel code
    localparam int num_ch = 8;

    // Power-up setup
    localparam alg_t alg_init = 3'd0;
    localparam rl_t  rl_init  = 2'b11;

    alg_t alg_bank [num_ch];
    rl_t  rl_bank  [num_ch];

    // Write port
    // Codes 3 and 7 are stored too, the mixer ignores them
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_ch; i++) begin
                alg_bank[i] <= alg_init;
                rl_bank[i]  <= rl_init;
            end
        end else if (reg_we) begin
            alg_bank[reg_ch] <= reg_alg;
            rl_bank[reg_ch]  <= reg_rl;
        end
    end

    // Read port follows the slot
    // Each slot sees its own channel setup
    always_comb begin
        alg = alg_bank[cur_ch];
        rl  = rl_bank[cur_ch];
    end

endmodule

`default_nettype wire

// ==== verilog/fm_slot_counter.sv ====
// ==========================================================================
// Frame slot counter, one step per clk_en. Slot 0 follows reset, so zero is
// high in the first cycle and the first frame starts right away
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "fm_mix_params.svh"

module fm_slot_counter (
    input  wire               clk,
    input  wire               reset,
    input  wire               clk_en,
    output fm_mix_pkg::ch_t   cur_ch,
    output fm_mix_pkg::op_t   cur_op,
    output logic              s1_enters,
    output logic              s2_enters,
    output logic              s3_enters,
    output logic              s4_enters,
    output logic              zero
);

    import fm_mix_pkg::*;

    // Last slot before wrap
    localparam slot_t last_slot = slot_t'(`FM_SLOTS - 1);

    slot_t slot;

    // Slot register
    // Holds its value while clk_en is low
    always_ff @(posedge clk) begin
        if (reset) begin
            slot <= '0;
        end else if (clk_en) begin
            if (slot == last_slot) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    // Channel in the low bits, operator in the high bits
    // So all channels see s1 before any sees s2
    assign cur_ch = slot[2:0];
    assign cur_op = slot[4:3];

    // One-hot operator decodes
    always_comb begin
        s1_enters = (cur_op == 2'd0);
        s2_enters = (cur_op == 2'd1);
        s3_enters = (cur_op == 2'd2);
        s4_enters = (cur_op == 2'd3);
    end

    // Start of frame
    // Stays high for as long as slot 0 lasts
    assign zero = (slot == '0);

endmodule

`default_nettype wire

// ==== verilog/fm_mix_pkg.sv ====
// ==========================================================================
// Field types shared by the slot counter, register bank and mixer
// ==========================================================================
`default_nettype none

package fm_mix_pkg;

    // Channel code within a slot group
    // Codes 3 and 7 are placeholders and never mix
    typedef logic [2:0] ch_t;

    // Operator index
    // 0 is s1, 3 is s4
    typedef logic [1:0] op_t;

    // FM connection algorithm, 0 to 7
    // Picks which operators are carriers
    typedef logic [2:0] alg_t;

    // Pan enables
    // Bit 1 left, bit 0 right
    typedef logic [1:0] rl_t;

    // Position in the 32-slot frame
    // Upper 2 bits operator, lower 3 bits channel
    typedef logic [4:0] slot_t;

endpackage

`default_nettype wire

// ==== include/fm_mix_params.svh ====
// ==========================================================================
// Shared widths for the FM mixing stage. FM_ACC_GUARD must cover FM_SLOTS
// full-scale additions. FM_MIX_NOMIX is a 0/1 value and not a defined flag
// ==========================================================================
`ifndef FM_MIX_PARAMS_SVH
`define FM_MIX_PARAMS_SVH

// Operator output width, two's complement
`define FM_OP_W 14

// Mixed sample width on the left and right outputs
`define FM_SND_W 16

// Headroom bits on top of the input width
// 5 bits hold 32 full-scale terms without wrap
`define FM_ACC_GUARD 5

// Time slots per output sample
// 4 operators x 8 channel codes
`define FM_SLOTS 32

// ADPCM mixing switch
// 0 lets ADPCM-A/B enter the sums in their slots
// 1 keeps both ADPCM slots silent
`define FM_MIX_NOMIX 1'b0

`endif
